// File: common/armPkg.sv
`default_nettype none

package armPkg;

  // ================================================
  // Encodings
  // ================================================

  // ALU operations of the execute stage
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_ORR = 3'd3,
    ALU_MOV = 3'd4
  } aluOp_t;

  // Same order as instr[6:5]
  typedef enum logic [1:0] {
    SH_LSL = 2'b00,
    SH_LSR = 2'b01,
    SH_ASR = 2'b10,
    SH_ROR = 2'b11
  } shiftType_t;

  // Decoded instruction class
  typedef enum logic [2:0] {
    IC_DATA   = 3'd0,
    IC_LOAD   = 3'd1,
    IC_STORE  = 3'd2,
    IC_BRANCH = 3'd3,
    IC_NOP    = 3'd4
  } instrClass_t;

  // Bypass source for an execute operand
  typedef enum logic [1:0] {
    FWD_RF  = 2'b00,
    FWD_WB  = 2'b01,
    FWD_MEM = 2'b10
  } fwdSel_t;

  // Immediate formats built in decode
  typedef enum logic [1:0] {
    IMM_ROT   = 2'd0,
    IMM_OFF12 = 2'd1,
    IMM_BR24  = 2'd2
  } immSrc_t;

  // SWI encoding, decodes as a bubble
  localparam logic [31:0] nopInstr = 32'hEF00_0000;

  // ================================================
  // Control and hazard bundles
  // ================================================

  typedef struct packed {
    logic       regSrc;     // Port 2 reads Rd instead of Rm
    immSrc_t    immSrc;
    logic       aluSrc;     // Operand B from immediate
    aluOp_t     aluOp;
    shiftType_t shType;
    logic       addOffset;  // U bit of LDR/STR
    logic       regWrite;
    logic       memWrite;
    logic       memToReg;
    logic       branch;
  } ctrlD_t;

  // Register numbers, reported by the datapath
  typedef struct packed {
    logic [3:0] ra1E;
    logic [3:0] ra2E;
    logic [3:0] ra1D;
    logic [3:0] ra2D;
    logic [3:0] wa3E;
    logic [3:0] wa3M;
    logic [3:0] wa3W;
  } hazardRegs_t;

  // Write flags, reported by the controller
  typedef struct packed {
    logic regWriteM;
    logic regWriteW;
    logic memToRegE;
    logic branchTakenE;
  } hazardFlags_t;

  typedef struct packed {
    hazardRegs_t  regs;
    hazardFlags_t flags;
  } hazardIn_t;

  typedef struct packed {
    logic    stallF;
    logic    stallD;
    logic    flushD;
    logic    flushE;
    fwdSel_t forwardAE;
    fwdSel_t forwardBE;
  } hazardOut_t;

  // Data memory request, valid during the M cycle
  typedef struct packed {
    logic        memWrite;
    logic [31:0] addr;
    logic [31:0] wdata;
  } dmemReq_t;

endpackage

`default_nettype wire

// File: datapath/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
  input  logic        clk,
  input  logic        arstN,
  input  logic        we,
  input  logic [3:0]  ra1,
  input  logic [3:0]  ra2,
  input  logic [3:0]  wa3,
  input  logic [31:0] wd3,
  input  logic [31:0] r15,
  output logic [31:0] rd1,
  output logic [31:0] rd2
);

  // R0..R14 only, R15 comes in from the PC path
  logic [31:0] regs [0:14];

  // Write on the rising edge
  always_ff @(posedge clk) begin
    if (we) begin
      regs[wa3] <= wd3;
    end
  end

  // Write-through, so a result in W is seen by D in the same cycle
  assign rd1 = (ra1 == 4'd15) ? r15 : ((we && wa3 == ra1) ? wd3 : regs[ra1]);
  assign rd2 = (ra2 == 4'd15) ? r15 : ((we && wa3 == ra2) ? wd3 : regs[ra2]);

  // The controller never lets a write to the PC reach writeback
  aNoR15Write : assert property (@(posedge clk) disable iff (!arstN)
    we |-> (wa3 != 4'd15))
    else $error("regFile: write to R15");

endmodule

`default_nettype wire

// File: datapath/aluShifter.sv
`timescale 1ns/1ps
`default_nettype none

module aluShifter (
  input  logic [31:0]        srcA,
  input  logic [31:0]        srcB,
  input  logic [4:0]         shAmt,
  input  armPkg::shiftType_t shType,
  input  logic               shiftEn,
  input  armPkg::aluOp_t     aluOp,
  output logic [31:0]        result
);
  import armPkg::*;

  logic [31:0] rorB;
  logic [31:0] shiftedB;

  // Rotate right, amount 0 leaves srcB unchanged
  assign rorB = (srcB >> shAmt) | (srcB << (6'd32 - {1'b0, shAmt}));

  // ================================================
  // Barrel shifter on operand B
  // ================================================
  // Also rotates the 8-bit immediate by twice the rot field
  always_comb begin
    shiftedB = srcB;
    if (shiftEn) begin
      unique case (shType)
        SH_LSL:  shiftedB = srcB << shAmt;
        SH_LSR:  shiftedB = srcB >> shAmt;
        SH_ASR:  shiftedB = $unsigned($signed(srcB) >>> shAmt);
        SH_ROR:  shiftedB = rorB;
        default: shiftedB = srcB;
      endcase
    end
  end

  // ================================================
  // ALU
  // ================================================
  always_comb begin
    unique case (aluOp)
      ALU_ADD: result = srcA + shiftedB;
      ALU_SUB: result = srcA - shiftedB;
      ALU_AND: result = srcA & shiftedB;
      ALU_ORR: result = srcA | shiftedB;
      // MOV ignores Rn
      ALU_MOV: result = shiftedB;
      default: result = shiftedB;
    endcase
  end

endmodule

`default_nettype wire

// File: datapath/datapath.sv
`timescale 1ns/1ps
`default_nettype none

module datapath #(
  parameter logic [31:0] resetPc = 32'h0000_0000
) (
  input  logic                 clk,
  input  logic                 arstN,
  input  logic [31:0]          instrF,
  input  logic [31:0]          readDataM,
  output logic [31:0]          pcF,
  output logic [31:0]          instrD,
  input  armPkg::ctrlD_t       ctrlD,
  input  logic                 aluSrcE,
  input  armPkg::aluOp_t       aluOpE,
  input  armPkg::shiftType_t   shTypeE,
  input  logic                 branchE,
  input  logic                 memWriteM,
  input  logic                 memToRegW,
  input  logic                 regWriteW,
  input  armPkg::hazardOut_t   hzOut,
  output armPkg::hazardRegs_t  regNums,
  output armPkg::dmemReq_t     dmemReq
);
  import armPkg::*;

  logic [31:0] pcPlus4F;
  logic [31:0] pcNextF;
  logic [3:0]  ra1D, ra2D, wa3D;
  logic [31:0] rd1D, rd2D, immD, off12D;
  logic [4:0]  shAmtD;
  logic        shiftEnD;
  logic [31:0] rd1E, rd2E, immE, pcPlus8E;
  logic [4:0]  shAmtE;
  logic        shiftEnE;
  logic [3:0]  ra1E, ra2E, wa3E;
  logic [31:0] srcAE, writeDataE, srcBE, aluResultE, branchTargetE;
  logic [31:0] aluOutM, writeDataM;
  logic [3:0]  wa3M;
  logic [31:0] aluOutW, readDataW, resultW;
  logic [3:0]  wa3W;

  // Bypass mux, memory stage wins over writeback
  function automatic logic [31:0] bypass(
    input fwdSel_t     sel,
    input logic [31:0] rfVal,
    input logic [31:0] wbVal,
    input logic [31:0] memVal
  );
    unique case (sel)
      FWD_MEM: return memVal;
      FWD_WB:  return wbVal;
      default: return rfVal;
    endcase
  endfunction

  // ================================================
  // Fetch
  // ================================================
  assign pcPlus4F = pcF + 32'd4;
  // Taken branch redirects fetch in the cycle after execute
  assign pcNextF  = branchE ? branchTargetE : pcPlus4F;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pcF <= resetPc;
    end else if (!hzOut.stallF) begin
      pcF <= pcNextF;
    end
  end

  // F/D instruction register, bubble on flush
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      instrD <= nopInstr;
    end else if (hzOut.flushD) begin
      instrD <= nopInstr;
    end else if (!hzOut.stallD) begin
      instrD <= instrF;
    end
  end

  // ================================================
  // Decode
  // ================================================
  assign ra1D = instrD[19:16];
  // Store data comes from Rd on port 2
  assign ra2D = ctrlD.regSrc ? instrD[15:12] : instrD[3:0];
  assign wa3D = instrD[15:12];

  // pcF is one word past the decode instruction, so pcPlus4F reads as PC+8
  regFile u_regFile (
    .clk   (clk),
    .arstN (arstN),
    .we    (regWriteW),
    .ra1   (ra1D),
    .ra2   (ra2D),
    .wa3   (wa3W),
    .wd3   (resultW),
    .r15   (pcPlus4F),
    .rd1   (rd1D),
    .rd2   (rd2D)
  );

  // Immediate builder, LDR/STR offset negated when U is clear
  assign off12D = {20'd0, instrD[11:0]};
  always_comb begin
    unique case (ctrlD.immSrc)
      IMM_ROT:   immD = {24'd0, instrD[7:0]};
      IMM_OFF12: immD = ctrlD.addOffset ? off12D : (32'd0 - off12D);
      IMM_BR24:  immD = {{6{instrD[23]}}, instrD[23:0], 2'b00};
      default:   immD = 32'd0;
    endcase
  end

  // Rot field doubled for the immediate form, shift_imm otherwise
  assign shAmtD   = ctrlD.aluSrc ? {instrD[11:8], 1'b0} : instrD[11:7];
  assign shiftEnD = (ctrlD.immSrc == IMM_ROT);

  // ================================================
  // Execute
  // ================================================
  always_ff @(posedge clk) begin
    rd1E     <= rd1D;
    rd2E     <= rd2D;
    immE     <= immD;
    pcPlus8E <= pcPlus4F;
    shAmtE   <= shAmtD;
    shiftEnE <= shiftEnD;
    ra1E     <= ra1D;
    ra2E     <= ra2D;
    wa3E     <= wa3D;
  end

  assign srcAE      = bypass(hzOut.forwardAE, rd1E, resultW, aluOutM);
  assign writeDataE = bypass(hzOut.forwardBE, rd2E, resultW, aluOutM);
  assign srcBE      = aluSrcE ? immE : writeDataE;

  aluShifter u_aluShifter (
    .srcA    (srcAE),
    .srcB    (srcBE),
    .shAmt   (shAmtE),
    .shType  (shTypeE),
    .shiftEn (shiftEnE),
    .aluOp   (aluOpE),
    .result  (aluResultE)
  );

  // Offset already shifted left by two in decode
  assign branchTargetE = pcPlus8E + immE;

  // ================================================
  // Memory
  // ================================================
  always_ff @(posedge clk) begin
    aluOutM    <= aluResultE;
    writeDataM <= writeDataE;
    wa3M       <= wa3E;
  end

  assign dmemReq = '{memWrite: memWriteM, addr: aluOutM, wdata: writeDataM};

  // ================================================
  // Writeback
  // ================================================
  always_ff @(posedge clk) begin
    aluOutW   <= aluOutM;
    readDataW <= readDataM;
    wa3W      <= wa3M;
  end

  assign resultW = memToRegW ? readDataW : aluOutW;

  assign regNums = '{ra1E: ra1E, ra2E: ra2E, ra1D: ra1D, ra2D: ra2D,
                     wa3E: wa3E, wa3M: wa3M, wa3W: wa3W};

  // Load-use and branch flush never overlap in one cycle
  aNoFlushStallD : assert property (@(posedge clk) disable iff (!arstN)
    !(hzOut.flushD && hzOut.stallD))
    else $error("datapath: flushD and stallD together");

endmodule

`default_nettype wire

// File: design/controller.sv
`timescale 1ns/1ps
`default_nettype none

module controller (
  input  logic                 clk,
  input  logic                 arstN,
  input  logic [31:0]          instrD,
  input  armPkg::hazardOut_t   hzOut,
  output armPkg::ctrlD_t       ctrlD,
  output logic                 aluSrcE,
  output armPkg::aluOp_t       aluOpE,
  output armPkg::shiftType_t   shTypeE,
  output logic                 branchE,
  output logic                 memWriteM,
  output logic                 memToRegW,
  output logic                 regWriteW,
  output armPkg::hazardFlags_t hzFlags
);
  import armPkg::*;

  instrClass_t classD;
  aluOp_t      dpOpD;
  logic        dpOkD;
  logic        regWriteE, memWriteE, memToRegE;
  logic        regWriteM, memToRegM;

  // ================================================
  // Decode
  // ================================================
  // Opcode field, anything outside the subset is rejected
  always_comb begin
    dpOkD = 1'b1;
    unique case (instrD[24:21])
      4'b0100: dpOpD = ALU_ADD;
      4'b0010: dpOpD = ALU_SUB;
      4'b0000: dpOpD = ALU_AND;
      4'b1100: dpOpD = ALU_ORR;
      4'b1101: dpOpD = ALU_MOV;
      default: begin
        dpOpD = ALU_ADD;
        dpOkD = 1'b0;
      end
    endcase
  end

  // Class from op[27:26], cond field ignored
  always_comb begin
    classD = IC_NOP;
    case (instrD[27:26])
      // No register-specified shifts, no multiply, no writes to R15
      2'b00: if (dpOkD && !(!instrD[25] && instrD[4]) && instrD[15:12] != 4'd15)
        classD = IC_DATA;
      // Word, immediate offset, no writeback
      2'b01: if (!instrD[25] && instrD[24] && !instrD[22] && !instrD[21]) begin
        if (!instrD[20]) classD = IC_STORE;
        else if (instrD[15:12] != 4'd15) classD = IC_LOAD;
      end
      // B only, BL would write LR
      2'b10: if (instrD[25] && !instrD[24]) classD = IC_BRANCH;
      default: classD = IC_NOP;
    endcase
  end

  always_comb begin
    ctrlD           = '0;
    ctrlD.addOffset = 1'b1;
    unique case (classD)
      IC_DATA: begin
        ctrlD.aluSrc   = instrD[25];
        ctrlD.aluOp    = dpOpD;
        ctrlD.shType   = instrD[25] ? SH_ROR : shiftType_t'(instrD[6:5]);
        ctrlD.regWrite = 1'b1;
      end
      IC_LOAD, IC_STORE: begin
        ctrlD.regSrc    = (classD == IC_STORE);
        ctrlD.immSrc    = IMM_OFF12;
        ctrlD.aluSrc    = 1'b1;
        ctrlD.addOffset = instrD[23];
        ctrlD.regWrite  = (classD == IC_LOAD);
        ctrlD.memToReg  = (classD == IC_LOAD);
        ctrlD.memWrite  = (classD == IC_STORE);
      end
      IC_BRANCH: begin
        ctrlD.immSrc = IMM_BR24;
        ctrlD.aluSrc = 1'b1;
        ctrlD.branch = 1'b1;
      end
      default: ;
    endcase
  end

  // ================================================
  // E, M and W control registers
  // ================================================
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      aluSrcE   <= 1'b0;
      aluOpE    <= ALU_ADD;
      shTypeE   <= SH_LSL;
      branchE   <= 1'b0;
      regWriteE <= 1'b0;
      memWriteE <= 1'b0;
      memToRegE <= 1'b0;
      regWriteM <= 1'b0;
      memWriteM <= 1'b0;
      memToRegM <= 1'b0;
      regWriteW <= 1'b0;
      memToRegW <= 1'b0;
    end else begin
      // flushE turns execute into a bubble
      aluSrcE   <= ctrlD.aluSrc & ~hzOut.flushE;
      aluOpE    <= hzOut.flushE ? ALU_ADD : ctrlD.aluOp;
      shTypeE   <= hzOut.flushE ? SH_LSL : ctrlD.shType;
      branchE   <= ctrlD.branch & ~hzOut.flushE;
      regWriteE <= ctrlD.regWrite & ~hzOut.flushE;
      memWriteE <= ctrlD.memWrite & ~hzOut.flushE;
      memToRegE <= ctrlD.memToReg & ~hzOut.flushE;
      regWriteM <= regWriteE;
      memWriteM <= memWriteE;
      memToRegM <= memToRegE;
      regWriteW <= regWriteM;
      memToRegW <= memToRegM;
    end
  end

  // Every branch is taken
  assign hzFlags = '{regWriteM: regWriteM, regWriteW: regWriteW,
                     memToRegE: memToRegE, branchTakenE: branchE};

  // Any word with the STR encoding, L bit clear, leaves regWrite low
  aStoreNoWrite : assert property (@(posedge clk) disable iff (!arstN)
    (instrD[27:26] == 2'b01 && !instrD[20]) |-> !ctrlD.regWrite)
    else $error("controller: STR with regWrite");

endmodule

`default_nettype wire

// File: design/hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
  input  armPkg::hazardIn_t  hzIn,
  output armPkg::hazardOut_t hzOut
);
  import armPkg::*;

  logic ldStall;
  logic brFlush;

  // Youngest producer first, then writeback
  function automatic fwdSel_t pickFwd(
    input logic [3:0] ra,
    input hazardIn_t  h
  );
    if (h.flags.regWriteM && ra == h.regs.wa3M) begin
      return FWD_MEM;
    end else if (h.flags.regWriteW && ra == h.regs.wa3W) begin
      return FWD_WB;
    end
    return FWD_RF;
  endfunction

  // Load in E feeding a source of the instruction in D
  assign ldStall = hzIn.flags.memToRegE &&
                   (hzIn.regs.wa3E == hzIn.regs.ra1D || hzIn.regs.wa3E == hzIn.regs.ra2D);

  // Branch resolved in E, kill D and E
  assign brFlush = hzIn.flags.branchTakenE;

  assign hzOut = '{
    stallF:    ldStall,
    stallD:    ldStall,
    flushD:    brFlush,
    flushE:    ldStall | brFlush,
    forwardAE: pickFwd(hzIn.regs.ra1E, hzIn),
    forwardBE: pickFwd(hzIn.regs.ra2E, hzIn)
  };

endmodule

`default_nettype wire

// File: design/armCore.sv
`timescale 1ns/1ps
`default_nettype none

module armCore #(
  parameter logic [31:0] resetPc = 32'h0000_0000
) (
  input  logic             clk,
  input  logic             arstN,
  output logic [31:0]      pcF,
  input  logic [31:0]      instrF,
  output armPkg::dmemReq_t dmemReq,
  input  logic [31:0]      readDataM
);
  import armPkg::*;

  logic [31:0]  instrD;
  ctrlD_t       ctrlD;
  logic         aluSrcE, branchE, memWriteM, memToRegW, regWriteW;
  aluOp_t       aluOpE;
  shiftType_t   shTypeE;
  hazardRegs_t  regNums;
  hazardFlags_t hzFlags;
  hazardIn_t    hzIn;
  hazardOut_t   hzOut;

  // Hazard inputs come half from each side
  assign hzIn = '{regs: regNums, flags: hzFlags};

  controller u_controller (
    .clk (clk), .arstN (arstN), .instrD (instrD), .hzOut (hzOut), .ctrlD (ctrlD),
    .aluSrcE (aluSrcE), .aluOpE (aluOpE), .shTypeE (shTypeE), .branchE (branchE),
    .memWriteM (memWriteM), .memToRegW (memToRegW), .regWriteW (regWriteW),
    .hzFlags (hzFlags)
  );

  datapath #(.resetPc(resetPc)) u_datapath (
    .clk (clk), .arstN (arstN), .instrF (instrF), .readDataM (readDataM), .pcF (pcF),
    .instrD (instrD), .ctrlD (ctrlD), .aluSrcE (aluSrcE), .aluOpE (aluOpE),
    .shTypeE (shTypeE), .branchE (branchE), .memWriteM (memWriteM),
    .memToRegW (memToRegW), .regWriteW (regWriteW), .hzOut (hzOut),
    .regNums (regNums), .dmemReq (dmemReq)
  );

  hazardUnit u_hazardUnit (
    .hzIn  (hzIn),
    .hzOut (hzOut)
  );

endmodule

`default_nettype wire

// File: dv/tbProgram.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// Data-processing opcodes, instr[24:21]
localparam logic [3:0] opAnd = 4'b0000;
localparam logic [3:0] opSub = 4'b0010;
localparam logic [3:0] opAdd = 4'b0100;
localparam logic [3:0] opOrr = 4'b1100;
localparam logic [3:0] opMov = 4'b1101;

// ================================================
// Instruction encoders, cond is always AL
// ================================================
task automatic emit(input logic [31:0] w);
  imem[8'(progLen)] = w;
  progLen++;
endtask

// Operand 2 is imm8 rotated right by 2*rot
task automatic dpImm(input logic [3:0] op, rd, rn, rot, input logic [7:0] imm8);
  emit({4'hE, 2'b00, 1'b1, op, 1'b0, rn, rd, rot, imm8});
endtask

// Operand 2 is Rm shifted by an immediate amount
task automatic dpReg(input logic [3:0] op, rd, rn, rm, input logic [1:0] sh,
                     input logic [4:0] amt);
  emit({4'hE, 2'b00, 1'b0, op, 1'b0, rn, rd, amt, sh, 1'b0, rm});
endtask

// Word access, pre-indexed, no writeback
task automatic ldrStr(input logic ld, up, input logic [3:0] rd, rn, input logic [11:0] off);
  emit({4'hE, 2'b01, 1'b0, 1'b1, up, 1'b0, 1'b0, ld, rn, rd, off});
endtask

task automatic branch(input logic [23:0] off);
  emit({4'hE, 3'b101, 1'b0, off});
endtask

// R0..R12, R13 holds the data base pointer
function automatic logic [3:0] pickReg();
  return 4'($urandom % 13);
endfunction

function automatic logic [3:0] pickOp();
  case ($urandom % 5)
    0: return opAdd;
    1: return opSub;
    2: return opAnd;
    3: return opOrr;
    default: return opMov;
  endcase
endfunction

// Word aligned, keeps base 0x100 inside the 1 KB data memory
function automatic logic [11:0] pickOff();
  return {5'd0, 5'($urandom % 32), 2'b00};
endfunction

task automatic storeReg(input logic [3:0] rd);
  ldrStr(1'b0, 1'($urandom % 2), rd, 4'd13, pickOff());
endtask

task automatic storeAll();
  for (int r = 0; r < 13; r++) begin
    storeReg(4'(r));
  end
endtask

// ================================================
// Program image
// ================================================
task automatic buildProgram();
  logic [3:0] rd;
  logic [3:0] rs;
  logic [3:0] prev1;
  logic [3:0] prev2;
  for (int i = 0; i < 256; i++) begin
    imem[8'(i)] = nopWord;
  end
  progLen = 0;
  // Every register gets a value, then R13 = 0x01 ROR 24
  for (int r = 0; r < 15; r++) begin
    dpImm(opMov, 4'(r), 4'd0, 4'($urandom % 16), 8'($urandom));
  end
  dpImm(opMov, 4'd13, 4'd0, 4'd12, 8'h01);
  // Dependent immediate chain, sources one or two back
  prev1 = 4'd0;
  prev2 = 4'd1;
  for (int i = 0; i < 15; i++) begin
    rd = pickReg();
    dpImm(pickOp(), rd, ($urandom % 2 == 1) ? prev1 : prev2, 4'($urandom % 16), 8'($urandom));
    if (i % 3 == 2) begin
      storeReg(rd);
    end
    prev2 = prev1;
    prev1 = rd;
  end
  storeAll();
  // Each shift type in turn, then a rotated immediate on the result
  for (int i = 0; i < 12; i++) begin
    rd = pickReg();
    dpReg(pickOp(), rd, pickReg(), pickReg(), 2'(i % 4), 5'(1 + $urandom % 31));
    dpImm(pickOp(), pickReg(), rd, 4'($urandom % 16), 8'($urandom));
  end
  storeAll();
  // Loads used right away, as ALU source or as store data
  for (int i = 0; i < 6; i++) begin
    rd = pickReg();
    ldrStr(1'b1, 1'($urandom % 2), rd, 4'd13, pickOff());
    if (i % 2 == 0) begin
      rs = pickReg();
      dpReg(opAdd, rs, rd, rd, 2'b00, 5'd1);
      storeReg(rs);
    end else begin
      storeReg(rd);
    end
  end
  // Taken branch over two stores
  dpImm(opMov, 4'd5, 4'd0, 4'd0, 8'hAA);
  dpImm(opMov, 4'd6, 4'd0, 4'd0, 8'h55);
  branch(24'd1);
  storeReg(4'd5);
  storeReg(4'd6);
  // PC reads through both register ports
  dpReg(opMov, 4'd9, 4'd0, 4'd15, 2'b00, 5'd0);
  storeReg(4'd9);
  dpImm(opAdd, 4'd10, 4'd15, 4'd0, 8'($urandom));
  storeReg(4'd10);
  storeAll();
  branch(24'hFFFFFE);
endtask

`endif

// File: dv/tbArmCore.sv
`timescale 1ns/1ps
`default_nettype none

module tbArmCore;
  import armPkg::*;

  localparam logic [31:0] resetPc = 32'h0000_0000;
  localparam logic [31:0] nopWord = 32'hEF00_0000;

  logic        clk = 1'b0;
  logic        arstN = 1'b0;
  logic [31:0] pcF;
  logic [31:0] instrF = nopWord;
  logic [31:0] readDataM = 32'h0;
  dmemReq_t    dmemReq;

  // Program image and data memory, both word indexed
  logic [31:0] imem [0:255];
  logic [31:0] dmem [0:255];
  int          progLen;

  // Store sequence predicted by the model
  logic [31:0] expAddr [0:255];
  logic [31:0] expData [0:255];
  int          expCount;
  int          storeIdx = 0;
  int          cycles = 0;
  int          cycleLimit;

  `include "tbProgram.svh"

  armCore #(.resetPc(resetPc)) u_dut (
    .clk       (clk),
    .arstN     (arstN),
    .pcF       (pcF),
    .instrF    (instrF),
    .dmemReq   (dmemReq),
    .readDataM (readDataM)
  );

  always #20 clk = ~clk;

  // Data memory contents before any store
  function automatic logic [31:0] fillWord(input logic [7:0] idx);
    return {idx, ~idx, idx ^ 8'h5A, idx + 8'hC3};
  endfunction

  // ================================================
  // Memories
  // ================================================
  // Both reads settle at the falling edge, no wait states
  always @(negedge clk) begin
    instrF    <= imem[pcF[9:2]];
    readDataM <= dmem[dmemReq.addr[9:2]];
  end

  // Store commits at the rising edge that ends the M cycle
  always @(posedge clk) begin
    if (!arstN) begin
      for (int i = 0; i < 256; i++) begin
        dmem[8'(i)] <= fillWord(8'(i));
      end
    end else if (dmemReq.memWrite) begin
      dmem[dmemReq.addr[9:2]] <= dmemReq.wdata;
      storeIdx <= storeIdx + 1;
    end
  end

  // ================================================
  // Reference model
  // ================================================
  function automatic logic [31:0] rotr(input logic [31:0] x, input logic [4:0] n);
    // Low half of the doubled word shifted right
    return 32'({x, x} >> n);
  endfunction

  function automatic logic [31:0] shiftVal(input logic [31:0] x, input logic [1:0] t,
                                           input logic [4:0] n);
    case (t)
      2'b00: return x << n;
      2'b01: return x >> n;
      // Sign bit copied into the upper word
      2'b10: return 32'({{32{x[31]}}, x} >> n);
      default: return rotr(x, n);
    endcase
  endfunction

  // Walks the image in program order until the branch to itself
  task automatic runModel();
    logic [31:0] regs [0:15];
    logic [31:0] mem [0:255];
    logic [31:0] pc, w, a, b, res, addr, target;
    for (int i = 0; i < 256; i++) begin
      mem[8'(i)] = fillWord(8'(i));
    end
    for (int i = 0; i < 16; i++) begin
      regs[4'(i)] = 32'h0;
    end
    pc = resetPc;
    expCount = 0;
    for (int n = 0; n < 1000; n++) begin
      w = imem[pc[9:2]];
      // R15 reads as PC+8
      a = (w[19:16] == 4'd15) ? pc + 32'd8 : regs[w[19:16]];
      if (w[27:25] == 3'b101) begin
        target = pc + 32'd8 + {{6{w[23]}}, w[23:0], 2'b00};
        if (target == pc) break;
        pc = target;
      end else if (w[27:26] == 2'b01) begin
        addr = w[23] ? a + {20'd0, w[11:0]} : a - {20'd0, w[11:0]};
        if (w[20]) begin
          regs[w[15:12]] = mem[addr[9:2]];
        end else begin
          expAddr[8'(expCount)] = addr;
          expData[8'(expCount)] = regs[w[15:12]];
          expCount++;
          mem[addr[9:2]] = regs[w[15:12]];
        end
        pc = pc + 32'd4;
      end else begin
        if (w[25]) begin
          b = rotr({24'd0, w[7:0]}, {w[11:8], 1'b0});
        end else begin
          b = shiftVal((w[3:0] == 4'd15) ? pc + 32'd8 : regs[w[3:0]], w[6:5], w[11:7]);
        end
        case (w[24:21])
          opAdd: res = a + b;
          opSub: res = a - b;
          opAnd: res = a & b;
          opOrr: res = a | b;
          default: res = b;
        endcase
        regs[w[15:12]] = res;
        pc = pc + 32'd4;
      end
    end
  endtask

  // ================================================
  // Error reporting
  // ================================================
  task automatic abortWithFail();
    $display("STATUS: FAIL");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic flagMismatch(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    $display("FAILED %s got 0x%08h expected 0x%08h", name, got, exp);
    abortWithFail();
  endtask

  task automatic describeFault(input string msg);
    $display("%s", msg);
    abortWithFail();
  endtask

  // ================================================
  // Store checks
  // ================================================
  // Sampled at the falling edge where dmemReq is settled
  aNoExtraStore : assert property (@(negedge clk) disable iff (!arstN)
    dmemReq.memWrite |-> (storeIdx < expCount))
    else describeFault("A store appeared beyond the end of the expected sequence");

  aStoreAddr : assert property (@(negedge clk) disable iff (!arstN)
    (dmemReq.memWrite && storeIdx < expCount) |-> (dmemReq.addr == expAddr[8'(storeIdx)]))
    else flagMismatch("dmemReq.addr", dmemReq.addr, expAddr[8'(storeIdx)]);

  aStoreData : assert property (@(negedge clk) disable iff (!arstN)
    (dmemReq.memWrite && storeIdx < expCount) |-> (dmemReq.wdata == expData[8'(storeIdx)]))
    else flagMismatch("dmemReq.wdata", dmemReq.wdata, expData[8'(storeIdx)]);

  // ================================================
  // Run control
  // ================================================
  initial begin
    void'($urandom(32'h235e872a));
    buildProgram();
    runModel();
    cycleLimit = 8 * progLen + 50;
    repeat (4) @(posedge clk);
    @(negedge clk);
    arstN = 1'b1;
    aResetPc : assert (pcF == resetPc)
      else flagMismatch("pcF", pcF, resetPc);
    // program parks on its last branch, so just let the clock run out
    while (cycles < cycleLimit) begin
      @(negedge clk);
      cycles++;
    end
    if (storeIdx == expCount) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      flagMismatch("storeCount", 32'(storeIdx), 32'(expCount));
    end
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+dv
common/armPkg.sv
datapath/regFile.sv
datapath/aluShifter.sv
datapath/datapath.sv
design/controller.sv
design/hazardUnit.sv
design/armCore.sv
dv/tbArmCore.sv

// File: Makefile
# Verilator flow for the armCore testbench

VERILATOR ?= verilator
TOP       ?= tbArmCore
RTL_TOP   ?= armCore
FILELIST  ?= tb.f
MDIR      ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

RTL_SRCS = $(filter-out dv/%,$(filter %.sv,$(shell cat $(FILELIST))))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(MDIR) -o $(TOP)

run: build
	-./$(MDIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG) || ! grep -q "STATUS: PASS" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(MDIR) $(LOG)
